/* verilog.f */
hdl/soc_bus_pkg.sv
hdl/soc_map_pkg.sv
hdl/mem_decoder.sv
hdl/bram.sv
hdl/print.sv
hdl/clint.sv
hdl/soc_mem.sv
tests/clk_gen.sv
tests/soc_mem_props.sv
tests/soc_mem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module soc_mem_tb -o soc_mem_sim

# The simulation's own status is not trusted, the log decides.
./obj_dir/soc_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
else
  exit 1
fi

/* tests/soc_mem_tb.sv */
`timescale 1ns/1ps

module soc_mem_tb;

  localparam int num_rows    = 24;
  localparam int cycle_limit = 40 * num_rows + 200;

  // Where the expected read value of a row comes from.
  localparam int src_none   = 0;
  localparam int src_model  = 1;
  localparam int src_fixed  = 2;
  localparam int src_count  = 3;
  localparam int src_rising = 4;
  localparam int src_cmp    = 5;  // mtimecmp low half set just above mtime

  logic               clk;
  logic               rst_n;
  logic               memory_valid;
  soc_bus_pkg::addr_t memory_addr;
  soc_bus_pkg::data_t memory_wdata;
  soc_bus_pkg::strb_t memory_wstrb;
  soc_bus_pkg::data_t memory_rdata;
  logic               memory_ready;
  logic [7:0]         char_out;
  logic               char_valid;
  logic               msip;
  logic               mtip;
  soc_bus_pkg::time_t mtime;

  soc_bus_pkg::addr_t row_addr  [num_rows];
  soc_bus_pkg::data_t row_wdata [num_rows];
  soc_bus_pkg::strb_t row_strb  [num_rows];
  int                 row_src   [num_rows];
  soc_bus_pkg::data_t row_exp   [num_rows];
  int                 row_count;

  logic [7:0]         model_mem [4096];
  logic [7:0]         char_queue [$];
  int                 chars_written;
  logic               exp_msip;
  soc_bus_pkg::data_t last_mtime;
  int                 errors;
  int                 cycles;

  clk_gen #(.period(4.0)) u_clk_gen (.clk(clk));

  soc_mem u_soc_mem (.*);

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
                         input soc_bus_pkg::strb_t strb, input int src,
                         input soc_bus_pkg::data_t exp);
    row_addr[row_count]  = addr;
    row_wdata[row_count] = wdata;
    row_strb[row_count]  = strb;
    row_src[row_count]   = src;
    row_exp[row_count]   = exp;
    row_count++;
  endtask

  task automatic build_table();
    // BRAM full words, partial overwrites, then read-back.
    add_row(32'h0000_0000, $urandom, 4'b1111, src_none, '0);
    add_row(32'h0000_0004, $urandom, 4'b1111, src_none, '0);
    add_row(32'h0000_0ffc, $urandom, 4'b1111, src_none, '0);
    add_row(32'h0000_0004, $urandom, 4'b0101, src_none, '0);
    add_row(32'h0000_0000, $urandom, 4'b1000, src_none, '0);
    add_row(32'h0000_0000, '0, 4'b0000, src_model, '0);
    add_row(32'h0000_0004, '0, 4'b0000, src_model, '0);
    add_row(32'h0000_0ffc, '0, 4'b0000, src_model, '0);
    // Unmapped accesses complete and leave the RAM alone.
    add_row(32'h3000_0000, 32'hdead_beef, 4'b1111, src_none, '0);
    add_row(32'h3000_0000, '0, 4'b0000, src_fixed, 32'h0);
    add_row(32'h0000_0000, '0, 4'b0000, src_model, '0);
    // Prints "Hi!" and a newline.
    add_row(32'h1000_0000, 32'h48, 4'b0001, src_none, '0);
    add_row(32'h1000_0000, 32'h69, 4'b0001, src_none, '0);
    add_row(32'h1000_0000, 32'h21, 4'b0001, src_none, '0);
    add_row(32'h1000_0000, 32'h0a, 4'b0001, src_none, '0);
    add_row(32'h1000_0000, '0, 4'b0000, src_count, '0);
    add_row(32'h0200_0000, 32'h1, 4'b1111, src_none, '0);
    add_row(32'h0200_0000, '0, 4'b0000, src_fixed, 32'h1);
    add_row(32'h0200_0000, 32'h0, 4'b1111, src_none, '0);
    add_row(32'h0200_0000, '0, 4'b0000, src_fixed, 32'h0);
    add_row(32'h0200_bff8, '0, 4'b0000, src_rising, '0);
    add_row(32'h0200_bff8, '0, 4'b0000, src_rising, '0);
    add_row(32'h0200_4004, 32'h0, 4'b1111, src_none, '0);
    add_row(32'h0200_4000, '0, 4'b1111, src_cmp, '0);
  endtask

  // Tracks the effect of a write on the BRAM model, the print stream and msip.
  task automatic note_write(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
                            input soc_bus_pkg::strb_t strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i] && addr < soc_map_pkg::bram_top_addr) begin
        model_mem[int'(addr[11:2]) * 4 + i] = wdata[8*i +: 8];
      end
    end
    if (addr == soc_map_pkg::print_base_addr && strb[0]) begin
      char_queue.push_back(wdata[7:0]);
      chars_written++;
    end
    if (addr == soc_map_pkg::clint_base_addr + {16'h0, soc_map_pkg::clint_msip_off} &&
        strb[0]) begin
      exp_msip = wdata[0];
    end
  endtask

  function automatic soc_bus_pkg::data_t model_word(input soc_bus_pkg::addr_t addr);
    int base;
    base = int'(addr[11:2]) * 4;
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  // Called 1 ns after a rising edge, and returns 1 ns after the completing edge.
  task automatic do_access(input soc_bus_pkg::addr_t addr, input soc_bus_pkg::data_t wdata,
                           input soc_bus_pkg::strb_t strb, output soc_bus_pkg::data_t rdata);
    memory_valid = 1'b1;
    memory_addr  = addr;
    memory_wdata = wdata;
    memory_wstrb = strb;
    @(negedge clk);
    while (!memory_ready) begin
      @(negedge clk);
    end
    rdata = memory_rdata;
    @(posedge clk);
    #1;
    memory_valid = 1'b0;
    memory_wstrb = '0;
  endtask

  always @(negedge clk) begin
    if (rst_n && char_valid) begin
      if (char_queue.size() == 0) begin
        errors++;
        $display("Error at %0t: a character was printed that was never written", $time);
      end else begin
        check_value("char_out", char_out, char_queue.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Error: the run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    soc_bus_pkg::data_t rdata;
    soc_bus_pkg::data_t wdata;
    soc_bus_pkg::data_t cmp_lo;
    void'($urandom(32'hae39c6bb));
    errors        = 0;
    cycles        = 0;
    row_count     = 0;
    chars_written = 0;
    exp_msip      = 1'b0;
    last_mtime    = '0;
    cmp_lo        = '0;
    rst_n         = 1'b0;
    memory_valid  = 1'b0;
    memory_addr   = '0;
    memory_wdata  = '0;
    memory_wstrb  = '0;
    build_table();
    @(negedge clk);
    check_value("memory_ready", memory_ready, 1'b0);
    check_value("char_valid", char_valid, 1'b0);
    check_value("msip", msip, 1'b0);
    check_value("mtip", mtip, 1'b0);
    check_value("mtime", mtime, 64'h0);
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < num_rows; i++) begin
      wdata = row_wdata[i];
      if (row_src[i] == src_cmp) begin
        cmp_lo = mtime[31:0] + 32'd20;
        wdata  = cmp_lo;
      end
      note_write(row_addr[i], wdata, row_strb[i]);
      do_access(row_addr[i], wdata, row_strb[i], rdata);
      case (row_src[i])
        src_model: check_value("memory_rdata", rdata, model_word(row_addr[i]));
        src_fixed: check_value("memory_rdata", rdata, row_exp[i]);
        src_count: check_value("memory_rdata", rdata, chars_written);
        src_rising: begin
          if (rdata <= last_mtime) begin
            errors++;
            $display("Error at %0t: mtime_lo did not increase, read %h after %h",
                     $time, rdata, last_mtime);
          end
          last_mtime = rdata;
        end
        src_cmp: begin
          // One count short of the compare value, mtip must still be low.
          while (mtime < {32'h0, cmp_lo} - 64'd1) begin
            @(negedge clk);
          end
          check_value("mtip", mtip, 1'b0);
          while (mtime < {32'h0, cmp_lo} + 64'd2) begin
            @(negedge clk);
          end
          check_value("mtip", mtip, 1'b1);
          @(posedge clk);
          #1;
        end
        default: begin
        end
      endcase
      check_value("msip", msip, exp_msip);
    end
    repeat (2) @(posedge clk);
    if (char_queue.size() != 0) begin
      errors++;
      $display("Error: %0d written characters never appeared on char_out", char_queue.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* tests/soc_mem_props.sv */
`timescale 1ns/1ps

module soc_mem_props (
  input logic clk,
  input logic rst_n,
  input logic memory_valid,
  input logic memory_ready,
  input logic bram_valid,
  input logic print_valid,
  input logic clint_valid
);

  // The decoder selects at most one target for an access.
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({bram_valid, print_valid, clint_valid}))
    else $error("more than one target valid is high");

  assert property (@(posedge clk) disable iff (!rst_n)
    memory_ready |=> !memory_ready)
    else $error("memory_ready stayed high for two cycles");

  // A new access is answered in the very next cycle.
  assert property (@(posedge clk) disable iff (!rst_n)
    memory_valid && !memory_ready |=> memory_ready)
    else $error("memory_ready did not follow memory_valid by one cycle");

endmodule

bind mem_decoder soc_mem_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .memory_valid (memory_valid),
  .memory_ready (memory_ready),
  .bram_valid   (bram_valid),
  .print_valid  (print_valid),
  .clint_valid  (clint_valid)
);

/* tests/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
  parameter real period = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

endmodule

/* hdl/soc_mem.sv */
`timescale 1ns/1ps

module soc_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memory_valid,
  input  soc_bus_pkg::addr_t memory_addr,
  input  soc_bus_pkg::data_t memory_wdata,
  input  soc_bus_pkg::strb_t memory_wstrb,
  output soc_bus_pkg::data_t memory_rdata,
  output logic               memory_ready,
  output logic [7:0]         char_out,
  output logic               char_valid,
  output logic               msip,
  output logic               mtip,
  output soc_bus_pkg::time_t mtime
);

  // Address, write data and strobes are shared by all targets.
  soc_bus_pkg::addr_t target_addr;
  soc_bus_pkg::data_t target_wdata;
  soc_bus_pkg::strb_t target_wstrb;

  logic               bram_valid;
  soc_bus_pkg::data_t bram_rdata;
  logic               bram_ready;

  logic               print_valid;
  soc_bus_pkg::data_t print_rdata;
  logic               print_ready;

  logic               clint_valid;
  soc_bus_pkg::data_t clint_rdata;
  logic               clint_ready;

  mem_decoder u_decoder (
    .clk          (clk),
    .rst_n        (rst_n),
    .memory_valid (memory_valid),
    .memory_addr  (memory_addr),
    .memory_wdata (memory_wdata),
    .memory_wstrb (memory_wstrb),
    .memory_rdata (memory_rdata),
    .memory_ready (memory_ready),
    .bram_valid   (bram_valid),
    .print_valid  (print_valid),
    .clint_valid  (clint_valid),
    .target_addr  (target_addr),
    .target_wdata (target_wdata),
    .target_wstrb (target_wstrb),
    .bram_rdata   (bram_rdata),
    .print_rdata  (print_rdata),
    .clint_rdata  (clint_rdata),
    .bram_ready   (bram_ready),
    .print_ready  (print_ready),
    .clint_ready  (clint_ready)
  );

  bram u_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (bram_valid),
    .addr  (target_addr),
    .wdata (target_wdata),
    .wstrb (target_wstrb),
    .rdata (bram_rdata),
    .ready (bram_ready)
  );

  print u_print (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid      (print_valid),
    .addr       (target_addr),
    .wdata      (target_wdata),
    .wstrb      (target_wstrb),
    .rdata      (print_rdata),
    .ready      (print_ready),
    .char_out   (char_out),
    .char_valid (char_valid)
  );

  clint u_clint (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (clint_valid),
    .addr  (target_addr),
    .wdata (target_wdata),
    .wstrb (target_wstrb),
    .rdata (clint_rdata),
    .ready (clint_ready),
    .msip  (msip),
    .mtip  (mtip),
    .mtime (mtime)
  );

endmodule

/* hdl/clint.sv */
`timescale 1ns/1ps

module clint (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  soc_bus_pkg::addr_t addr,
  input  soc_bus_pkg::data_t wdata,
  input  soc_bus_pkg::strb_t wstrb,
  output soc_bus_pkg::data_t rdata,
  output logic               ready,
  output logic               msip,
  output logic               mtip,
  output soc_bus_pkg::time_t mtime
);

  soc_bus_pkg::time_t mtimecmp;
  soc_bus_pkg::data_t read_word;
  logic               access;
  logic               wr_en;

  function automatic soc_bus_pkg::data_t merge_bytes(
    input soc_bus_pkg::data_t old_word,
    input soc_bus_pkg::data_t new_word,
    input soc_bus_pkg::strb_t strb
  );
    soc_bus_pkg::data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign access = valid && !ready;
  assign wr_en  = access && (wstrb != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
      mtime <= '0;
      mtip  <= 1'b0;
    end else begin
      ready <= access;
      mtime <= mtime + 1'b1;
      mtip  <= (mtime >= mtimecmp);
    end
  end

  // mtime is read-only here, so writes to its offsets fall through.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      msip     <= 1'b0;
      mtimecmp <= '1;
    end else if (wr_en) begin
      case (addr[15:0])
        soc_map_pkg::clint_msip_off: begin
          if (wstrb[0]) begin
            msip <= wdata[0];
          end
        end
        soc_map_pkg::clint_mtimecmp_lo_off: begin
          mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
        end
        soc_map_pkg::clint_mtimecmp_hi_off: begin
          mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    case (addr[15:0])
      soc_map_pkg::clint_msip_off:        read_word = {31'h0, msip};
      soc_map_pkg::clint_mtimecmp_lo_off: read_word = mtimecmp[31:0];
      soc_map_pkg::clint_mtimecmp_hi_off: read_word = mtimecmp[63:32];
      soc_map_pkg::clint_mtime_lo_off:    read_word = mtime[31:0];
      soc_map_pkg::clint_mtime_hi_off:    read_word = mtime[63:32];
      default:                            read_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= read_word;
    end
  end

endmodule

/* hdl/print.sv */
`timescale 1ns/1ps

module print (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  soc_bus_pkg::addr_t addr,
  input  soc_bus_pkg::data_t wdata,
  input  soc_bus_pkg::strb_t wstrb,
  output soc_bus_pkg::data_t rdata,
  output logic               ready,
  output logic [7:0]         char_out,
  output logic               char_valid
);

  soc_bus_pkg::data_t char_count;
  logic               access;
  logic               char_wr;

  assign access  = valid && !ready;
  assign char_wr = access && wstrb[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready      <= 1'b0;
      char_valid <= 1'b0;
      char_count <= '0;
    end else begin
      ready      <= access;
      char_valid <= char_wr;
      if (char_wr) begin
        char_count <= char_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (char_wr) begin
      char_out <= wdata[7:0];
    end
  end

  // The count sits at the first word of the window. Other words read zero.
  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= (addr[31:2] == '0) ? char_count : '0;
    end
  end

endmodule

/* hdl/bram.sv */
`timescale 1ns/1ps

module bram (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  soc_bus_pkg::addr_t addr,
  input  soc_bus_pkg::data_t wdata,
  input  soc_bus_pkg::strb_t wstrb,
  output soc_bus_pkg::data_t rdata,
  output logic               ready
);

  soc_bus_pkg::data_t mem [soc_map_pkg::bram_words];
  logic [9:0]         word_idx;
  logic               access;

  assign word_idx = addr[11:2];

  // The access is taken once, on the first edge that sees valid.
  assign access = valid && !ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb[i]) begin
          mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // A write also returns the old word. The master ignores it.
  always_ff @(posedge clk) begin
    if (access) begin
      rdata <= mem[word_idx];
    end
  end

endmodule

/* hdl/mem_decoder.sv */
`timescale 1ns/1ps

module mem_decoder (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memory_valid,
  input  soc_bus_pkg::addr_t memory_addr,
  input  soc_bus_pkg::data_t memory_wdata,
  input  soc_bus_pkg::strb_t memory_wstrb,
  output soc_bus_pkg::data_t memory_rdata,
  output logic               memory_ready,
  output logic               bram_valid,
  output logic               print_valid,
  output logic               clint_valid,
  output soc_bus_pkg::addr_t target_addr,
  output soc_bus_pkg::data_t target_wdata,
  output soc_bus_pkg::strb_t target_wstrb,
  input  soc_bus_pkg::data_t bram_rdata,
  input  soc_bus_pkg::data_t print_rdata,
  input  soc_bus_pkg::data_t clint_rdata,
  input  logic               bram_ready,
  input  logic               print_ready,
  input  logic               clint_ready
);

  soc_bus_pkg::addr_t base_addr;
  logic               unmapped_valid;
  logic               unmapped_ready;

  // Ranges are checked CLINT first, then print, then BRAM.
  always_comb begin
    bram_valid     = 1'b0;
    print_valid    = 1'b0;
    clint_valid    = 1'b0;
    unmapped_valid = 1'b0;
    base_addr      = '0;
    if (memory_addr >= soc_map_pkg::clint_base_addr &&
        memory_addr < soc_map_pkg::clint_top_addr) begin
      clint_valid = memory_valid;
      base_addr   = soc_map_pkg::clint_base_addr;
    end else if (memory_addr >= soc_map_pkg::print_base_addr &&
                 memory_addr < soc_map_pkg::print_top_addr) begin
      print_valid = memory_valid;
      base_addr   = soc_map_pkg::print_base_addr;
    end else if (memory_addr >= soc_map_pkg::bram_base_addr &&
                 memory_addr < soc_map_pkg::bram_top_addr) begin
      bram_valid = memory_valid;
      base_addr  = soc_map_pkg::bram_base_addr;
    end else begin
      unmapped_valid = memory_valid;
    end
  end

  assign target_addr  = memory_addr - base_addr;
  assign target_wdata = memory_wdata;
  assign target_wstrb = memory_wstrb;

  // Misses get the same one-cycle answer as a real target so the bus never stalls.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= unmapped_valid && !unmapped_ready;
    end
  end

  // An unmapped access reads zero, as does the idle bus.
  always_comb begin
    memory_rdata = '0;
    if (bram_ready) begin
      memory_rdata = bram_rdata;
    end else if (print_ready) begin
      memory_rdata = print_rdata;
    end else if (clint_ready) begin
      memory_rdata = clint_rdata;
    end
  end

  assign memory_ready = bram_ready | print_ready | clint_ready | unmapped_ready;

endmodule

/* hdl/soc_map_pkg.sv */
package soc_map_pkg;

  // Address windows. Each top address is the first byte past the window.
  localparam soc_bus_pkg::addr_t bram_base_addr  = 32'h0000_0000;
  localparam soc_bus_pkg::addr_t bram_top_addr   = 32'h0000_1000;

  localparam soc_bus_pkg::addr_t print_base_addr = 32'h1000_0000;
  localparam soc_bus_pkg::addr_t print_top_addr  = 32'h1000_1000;

  localparam soc_bus_pkg::addr_t clint_base_addr = 32'h0200_0000;
  localparam soc_bus_pkg::addr_t clint_top_addr  = 32'h0201_0000;

  // RAM depth in 32-bit words.
  localparam int bram_words = 1024;

  // CLINT register offsets from the CLINT base.
  localparam logic [15:0] clint_msip_off        = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_lo_off = 16'h4000;
  localparam logic [15:0] clint_mtimecmp_hi_off = 16'h4004;
  localparam logic [15:0] clint_mtime_lo_off    = 16'hBFF8;
  localparam logic [15:0] clint_mtime_hi_off    = 16'hBFFC;

endpackage

/* hdl/soc_bus_pkg.sv */
package soc_bus_pkg;

  // Byte address on the memory bus.
  typedef logic [31:0] addr_t;

  // One bus data word.
  typedef logic [31:0] data_t;

  // Byte write strobes. All zero means the access is a read.
  typedef logic [3:0] strb_t;

  // Width of the mtime counter and the mtimecmp register.
  typedef logic [63:0] time_t;

endpackage
